//--- common/mont_macros.svh
// width and queue depth of the modular multiply unit, included by the package, RTL and testbench

`ifndef MONT_MACROS_SVH
`define MONT_MACROS_SVH

//////////////////////////////////////////////////
// operand size
//////////////////////////////////////////////////

// operand width W, also the number of core iterations
// 32 keeps the reference arithmetic inside 64-bit math
`define MONT_WID 32

//////////////////////////////////////////////////
// job queue
//////////////////////////////////////////////////

// job entries held ahead of the core
`define MONT_QDEPTH 4

// read and write pointer width, log2 of the depth
// must track MONT_QDEPTH, pointers wrap naturally
`define MONT_QPTR_W 2

`endif

//--- common/mont_pkg.sv
// job and result types passed between the queue, the multiplier core and the reducer

`include "mont_macros.svh"

package mont_pkg;

    //////////////////////////////////////////////////
    // request side
    //////////////////////////////////////////////////

    // one complete request as strobed in by the caller
    // m odd, a and b already below m
    typedef struct packed
    {
        logic [`MONT_WID-1:0] a;
        logic [`MONT_WID-1:0] b;
        logic [`MONT_WID-1:0] m;
    } mont_job_t;

    //////////////////////////////////////////////////
    // core side
    //////////////////////////////////////////////////

    // unreduced product from the serial core
    // always below 2m, hence one extra bit
    typedef struct packed
    {
        logic [`MONT_WID:0] r;
    } mont_raw_t;

endpackage

//--- hdl/mont_request_queue.sv
// circular job buffer between caller and core, push and pop strobes with first-word-fall-through head

`timescale 1ns/1ps

`include "mont_macros.svh"

module mont_request_queue
(
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  mont_pkg::mont_job_t job_in,
    input  logic                pop,
    output mont_pkg::mont_job_t head,
    output logic                empty,
    output logic                full,
    output logic                overflow
);

    import mont_pkg::*;

    // occupancy value when every entry is taken
    localparam logic [`MONT_QPTR_W:0] QCOUNT_FULL = `MONT_QDEPTH;

    //////////////////////////////////////////////////
    // storage and pointers
    //////////////////////////////////////////////////

    // job entries, payload only
    mont_job_t                 mem [0:`MONT_QDEPTH-1];

    logic [`MONT_QPTR_W-1:0]   wr_ptr;
    logic [`MONT_QPTR_W-1:0]   rd_ptr;
    // one bit wider than pointers to tell full from empty
    logic [`MONT_QPTR_W:0]     count;

    // push taken unless full
    // when full, a pop in the same cycle frees the slot being written
    logic                      push_ok;

    assign push_ok = push && (!full || pop);

    assign empty = (count == '0);
    assign full  = (count == QCOUNT_FULL);

    // head shown without a read cycle
    assign head = mem[rd_ptr];

    //////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (push_ok)
        begin
            mem[wr_ptr] <= job_in;
        end
    end

    //////////////////////////////////////////////////
    // pointers, occupancy, overflow
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (push_ok)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // both strobes together leave occupancy unchanged
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // dropped request, sticky until reset
            if (push && full && !pop)
            begin
                overflow <= 1'b1;
            end
        end
    end

    // the core only pops a job that is actually at the head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

//--- mont_core/mont_mul_serial.sv
// bit-serial radix-2 Montgomery multiplier, one operand bit per clock, result below 2m

`timescale 1ns/1ps

`include "mont_macros.svh"

module mont_mul_serial
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 empty,
    input  mont_pkg::mont_job_t  job,
    output logic                 pop,
    output logic                 raw_valid,
    output mont_pkg::mont_raw_t  raw,
    output logic [`MONT_WID-1:0] modulus,
    output logic                 active
);

    import mont_pkg::*;

    // iteration counter sized to reach W-1
    localparam int                CNT_W    = $clog2(`MONT_WID);
    localparam logic [CNT_W-1:0]  CNT_LAST = CNT_W'(`MONT_WID - 1);

    //////////////////////////////////////////////////
    // datapath registers
    //////////////////////////////////////////////////

    // scanned operand, shifts right one bit per iteration
    logic [`MONT_WID-1:0]   a_sr;
    logic [`MONT_WID-1:0]   b_reg;
    logic [`MONT_WID-1:0]   m_reg;
    // running partial product, W+1 bits
    mont_raw_t              acc;

    // control
    logic                   run;
    logic [CNT_W-1:0]       cnt;

    // iteration arithmetic, two bits above W for r + b + m
    logic [`MONT_WID+1:0]   sum_b;
    logic [`MONT_WID+1:0]   sum_m;
    logic [`MONT_WID:0]     acc_next;

    //////////////////////////////////////////////////
    // one radix-2 step
    //////////////////////////////////////////////////

    // add b when the scanned bit is set
    assign sum_b = {1'b0, acc.r} + {2'b00, (a_sr[0] ? b_reg : '0)};
    // add m when odd so the halving is exact
    assign sum_m = sum_b + {2'b00, (sum_b[0] ? m_reg : '0)};
    assign acc_next = sum_m[`MONT_WID+1:1];

    //////////////////////////////////////////////////
    // load and control
    //////////////////////////////////////////////////

    // idle core takes the head job as soon as one is present
    assign pop = !run && !empty;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            run       <= 1'b0;
            cnt       <= '0;
            raw_valid <= 1'b0;
        end
        else
        begin
            raw_valid <= 1'b0;
            if (pop)
            begin
                run <= 1'b1;
                cnt <= '0;
            end
            else if (run)
            begin
                cnt <= cnt + 1'b1;
                // last bit retired, hand off next cycle
                if (cnt == CNT_LAST)
                begin
                    run       <= 1'b0;
                    raw_valid <= 1'b1;
                end
            end
        end
    end

    // operands and accumulator, payload only
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            a_sr  <= job.a;
            b_reg <= job.b;
            m_reg <= job.m;
            acc   <= '0;
        end
        else if (run)
        begin
            a_sr  <= {1'b0, a_sr[`MONT_WID-1:1]};
            acc.r <= acc_next;
        end
    end

    assign raw     = acc;
    // held until the next load
    assign modulus = m_reg;
    // covers the hand-off cycle too
    assign active  = run || raw_valid;

    // caller contract, odd modulus
    a_m_odd: assert property (@(posedge clk) disable iff (rst) $past(pop) |-> m_reg[0]);

    // partial product never escapes the 2m bound
    a_raw_bound: assert property (@(posedge clk) disable iff (rst)
        raw_valid |-> (raw.r < {m_reg, 1'b0}));

endmodule

//--- hdl/mont_final_reduce.sv
// final conditional subtraction of m, registers the fully reduced result with a done pulse

`timescale 1ns/1ps

`include "mont_macros.svh"

module mont_final_reduce
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 raw_valid,
    input  mont_pkg::mont_raw_t  raw,
    input  logic [`MONT_WID-1:0] modulus,
    output logic                 done,
    output logic [`MONT_WID-1:0] result
);

    import mont_pkg::*;

    // raw minus m, meaningful only when raw >= m
    mont_raw_t              diff;
    logic                   ge_m;
    // modulus of the job now on the result output
    logic [`MONT_WID-1:0]   mod_q;

    assign diff.r = raw.r - {1'b0, modulus};
    assign ge_m   = (raw.r >= {1'b0, modulus});

    //////////////////////////////////////////////////
    // output stage
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            done <= 1'b0;
        end
        else
        begin
            done <= raw_valid;
        end
    end

    // raw below 2m, so one subtraction is enough
    always_ff @(posedge clk)
    begin
        if (raw_valid)
        begin
            result <= ge_m ? diff.r[`MONT_WID-1:0] : raw.r[`MONT_WID-1:0];
            mod_q  <= modulus;
        end
    end

    a_reduced: assert property (@(posedge clk) disable iff (rst) done |-> (result < mod_q));

endmodule

//--- hdl/mont_unit.sv
// modular multiply unit top, request queue feeding the serial Montgomery core and final reducer

`timescale 1ns/1ps

`include "mont_macros.svh"

module mont_unit
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  mont_pkg::mont_job_t  job,
    output logic                 done,
    output logic [`MONT_WID-1:0] result,
    output logic                 busy,
    output logic                 overflow
);

    import mont_pkg::*;

    //////////////////////////////////////////////////
    // internal wiring
    //////////////////////////////////////////////////

    // queue to core
    mont_job_t              head_job;
    logic                   q_empty;
    logic                   q_pop;

    // core to reducer
    logic                   raw_valid;
    mont_raw_t              raw;
    logic [`MONT_WID-1:0]   core_mod;
    logic                   core_active;

    // anything waiting or still being worked
    assign busy = !q_empty || core_active;

    mont_request_queue u_queue
    (
        .clk      (clk),
        .rst      (rst),
        .push     (req),
        .job_in   (job),
        .pop      (q_pop),
        .head     (head_job),
        .empty    (q_empty),
        .full     (),
        .overflow (overflow)
    );

    mont_mul_serial u_core
    (
        .clk       (clk),
        .rst       (rst),
        .empty     (q_empty),
        .job       (head_job),
        .pop       (q_pop),
        .raw_valid (raw_valid),
        .raw       (raw),
        .modulus   (core_mod),
        .active    (core_active)
    );

    // reducer accepts a new product every cycle
    mont_final_reduce u_reduce
    (
        .clk       (clk),
        .rst       (rst),
        .raw_valid (raw_valid),
        .raw       (raw),
        .modulus   (core_mod),
        .done      (done),
        .result    (result)
    );

endmodule

//--- tb/tb_clock_gen.sv
// testbench clock source for the modular multiply unit, 100 ns period starting low

`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk
);

    // half period 50 ns
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

endmodule

//--- tb/mont_unit_tb.sv
// self-checking testbench for the modular multiply unit, run as top with the sources.f file list

`timescale 1ns/1ps

`include "mont_macros.svh"

module mont_unit_tb;

    import mont_pkg::*;

    localparam int W         = `MONT_WID;
    localparam int D         = `MONT_QDEPTH;
    localparam int SOAK_JOBS = 40;
    // req edge to done pulse in ns
    localparam longint LAT_NS = (W + 3) * 100;
    // lone, edge, burst, overflow and soak jobs
    localparam int JOBS = 1 + 3 + D + (D + 2) + SOAK_JOBS;
    localparam longint WATCHDOG_NS = longint'(JOBS * (W + 3) * D + 2000) * 100;

    logic                 clk;
    logic                 rst;
    logic                 req;
    mont_job_t            job;
    logic                 done;
    logic [W-1:0]         result;
    logic                 busy;
    logic                 overflow;

    //////////////////////////////////////////////////
    // scoreboard and queue model state
    //////////////////////////////////////////////////

    // {m, expected result} per accepted job
    logic [2*W-1:0]       sb_q [$];
    logic [2*W-1:0]       sb_entry;
    int                   q_cnt_m;
    int                   core_left_m;
    bit                   pop_m;
    bit                   push_m;
    bit                   ovf_model;
    int                   dropped_count;
    int                   done_count;
    bit                   drained;
    logic [W-1:0]         last_result;
    time                  last_done_time;
    time                  t_issue;
    logic [15:0]          lfsr_state;
    mont_job_t            j;
    int                   base_done;
    int                   base_drop;

    tb_clock_gen u_clk (.clk(clk));

    mont_unit uut
    (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .job      (job),
        .done     (done),
        .result   (result),
        .busy     (busy),
        .overflow (overflow)
    );

    //////////////////////////////////////////////////
    // failure reporting
    //////////////////////////////////////////////////

    task automatic fail_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic value_error(input string what, input logic [63:0] exp, input logic [63:0] act);
        $display("[ERROR] %0t ns: %s, expected %h, got %h", $time, what, exp, act);
        fail_run();
    endtask

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    // 16-bit Galois LFSR with taps x^16+x^14+x^13+x^11+1
    // one bit per step
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[15:1]} ^ (out ? 16'hB400 : 16'h0000);
        return out;
    endfunction

    function automatic logic [W-1:0] rand_bits(input int n);
        logic [W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[W-2:0], lfsr_bit()};
        end
        return v;
    endfunction

    // m odd with its top bit set
    // a and b reduced below m
    function automatic mont_job_t random_job();
        mont_job_t r;
        r.m = rand_bits(W) | {1'b1, {(W-2){1'b0}}, 1'b1};
        r.a = rand_bits(W) % r.m;
        r.b = rand_bits(W) % r.m;
        return r;
    endfunction

    // radix-2 Montgomery a*b*2^-W mod m with the final subtraction
    function automatic logic [W-1:0] mont_model(input logic [W-1:0] a, b, m);
        logic [63:0] r;
        r = 64'd0;
        for (int i = 0; i < W; i++)
        begin
            if (a[i])
                r = r + b;
            if (r[0])
                r = r + m;
            r = r >> 1;
        end
        if (r >= m)
            r = r - m;
        return r[W-1:0];
    endfunction

    // 2^-W mod m by W exact halvings of 1
    function automatic logic [W-1:0] inv_pow2(input logic [W-1:0] m);
        logic [63:0] r;
        r = 64'd1;
        repeat (W)
        begin
            if (r[0])
                r = r + m;
            r = r >> 1;
        end
        return r[W-1:0];
    endfunction

    // all tasks start and end on a falling edge
    task automatic apply_reset();
        rst = 1'b1;
        req = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic issue(input mont_job_t jb);
        req = 1'b1;
        job = jb;
        @(negedge clk);
        req = 1'b0;
    endtask

    task automatic drain();
        @(posedge clk);
        while (!drained)
            @(posedge clk);
        @(negedge clk);
    endtask

    task automatic lone_job(input mont_job_t jb);
        t_issue = $time;
        issue(jb);
        drain();
        assert (last_done_time - t_issue == LAT_NS)
            else value_error("lone job latency ns", LAT_NS, last_done_time - t_issue);
    endtask

    //////////////////////////////////////////////////
    // queue and core occupancy model
    //////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (rst)
        begin
            q_cnt_m     = 0;
            core_left_m = 0;
            ovf_model   = 1'b0;
            sb_q.delete();
        end
        else
        begin
            // idle core pops the head
            // a full queue takes a push only together with a pop
            pop_m  = (core_left_m == 0) && (q_cnt_m != 0);
            push_m = req && ((q_cnt_m < D) || pop_m);
            if (req && !push_m)
            begin
                ovf_model = 1'b1;
                dropped_count++;
            end
            if (push_m)
            begin
                sb_q.push_back({job.m, mont_model(job.a, job.b, job.m)});
            end
            q_cnt_m = q_cnt_m + int'(push_m) - int'(pop_m);
            // W iteration edges before the next pop
            if (pop_m)
                core_left_m = W;
            else if (core_left_m != 0)
                core_left_m--;
        end
    end

    //////////////////////////////////////////////////
    // output checks on the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (done)
        begin
            assert (sb_q.size() != 0)
                else value_error("done with no job outstanding", 0, result);
            sb_entry = sb_q.pop_front();
            assert (result == sb_entry[W-1:0])
                else value_error("result", sb_entry[W-1:0], result);
            assert (result < sb_entry[2*W-1:W])
                else value_error("result not below m", sb_entry[2*W-1:W], result);
            last_result    = result;
            last_done_time = $time;
            done_count++;
        end
        // busy until the last done pulse
        assert (busy == (sb_q.size() != 0))
            else value_error("busy", sb_q.size() != 0, busy);
        assert (overflow == ovf_model)
            else value_error("overflow", ovf_model, overflow);
        drained = (sb_q.size() == 0) && !busy;
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else
        begin
            $display("done stayed high for more than one cycle");
            fail_run();
        end

    a_ovf_sticky: assert property (@(posedge clk) disable iff (rst) $past(overflow) |-> overflow)
        else
        begin
            $display("overflow dropped without a reset");
            fail_run();
        end

    a_idle_quiet: assert property (@(posedge clk) disable iff (rst) !busy |=> !done)
        else
        begin
            $display("done pulsed while the unit was idle");
            fail_run();
        end

    // watchdog sized from the job count
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        fail_run();
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial
    begin
        rst            = 1'b1;
        req            = 1'b0;
        job            = '0;
        lfsr_state     = 16'd47379;
        dropped_count  = 0;
        done_count     = 0;
        drained        = 1'b0;
        apply_reset();
        // quiet after reset
        repeat (3) @(negedge clk);

        // single job on an idle unit
        lone_job(random_job());

        // edge operands
        j = random_job();
        j.a = '0;
        lone_job(j);
        assert (last_result == '0) else value_error("a = 0", 0, last_result);
        j.a = 1;
        j.b = 1;
        lone_job(j);
        assert (last_result == inv_pow2(j.m))
            else value_error("a = b = 1", inv_pow2(j.m), last_result);
        // (m-1)^2 is 1 mod m
        j.a = j.m - 1;
        j.b = j.m - 1;
        lone_job(j);
        assert (last_result == inv_pow2(j.m))
            else value_error("a = b = m-1", inv_pow2(j.m), last_result);

        // back-to-back burst
        base_done = done_count;
        repeat (D)
            issue(random_job());
        drain();
        assert (done_count - base_done == D)
            else value_error("burst done count", D, done_count - base_done);

        // overflow with one job popped, D queued and the rest dropped
        base_done = done_count;
        base_drop = dropped_count;
        repeat (D + 2)
            issue(random_job());
        drain();
        assert (done_count - base_done == D + 1)
            else value_error("overflow done count", D + 1, done_count - base_done);
        assert (dropped_count - base_drop == 1)
            else value_error("dropped requests", 1, dropped_count - base_drop);
        assert (overflow) else value_error("overflow after drain", 1, overflow);
        apply_reset();
        @(negedge clk);
        assert (!overflow) else value_error("overflow after reset", 0, overflow);

        // random soak that never offers to a full queue
        base_done = done_count;
        for (int n = 0; n < SOAK_JOBS; n++)
        begin
            repeat (rand_bits(4))
                @(negedge clk);
            while (q_cnt_m >= D)
                @(negedge clk);
            issue(random_job());
        end
        drain();
        assert (done_count - base_done == SOAK_JOBS)
            else value_error("soak done count", SOAK_JOBS, done_count - base_done);

        if (sb_q.size() == 0 && !busy && !overflow)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
        begin
            $display("unit not idle at the end of the run");
            fail_run();
        end
    end

endmodule

//--- sources.f
+incdir+common
common/mont_pkg.sv
hdl/mont_request_queue.sv
mont_core/mont_mul_serial.sv
hdl/mont_final_reduce.sv
hdl/mont_unit.sv
tb/tb_clock_gen.sv
tb/mont_unit_tb.sv
